// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP ?= cpu_core_tb
FILELIST ?= files.f
PASS_MSG = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator output is searched for the pass line; a missing line fails the target.
run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t; // Data, address and instruction word.
	typedef logic [4:0] reg_idx_t; // Register number.

	// Primary opcodes, instruction bits 31:26.
	localparam logic [5:0] op_rtype = 6'h00; // Register type, see the function field.
	localparam logic [5:0] op_j = 6'h02;
	localparam logic [5:0] op_jal = 6'h03;
	localparam logic [5:0] op_beq = 6'h04;
	localparam logic [5:0] op_bne = 6'h05;
	localparam logic [5:0] op_addi = 6'h08;
	localparam logic [5:0] op_ori = 6'h0d;
	localparam logic [5:0] op_lui = 6'h0f;
	localparam logic [5:0] op_lw = 6'h23;
	localparam logic [5:0] op_sw = 6'h2b;

	// Function field of register type instructions, bits 5:0.
	localparam logic [5:0] fn_jr = 6'h08;
	localparam logic [5:0] fn_jalr = 6'h09;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	typedef enum logic [2:0] {
		alu_add, // Also used for address calculation.
		alu_sub,
		alu_and,
		alu_or,
		alu_slt, // Signed compare, result is zero or one.
		alu_lui // Moves the low half of operand b to the upper half.
	} alu_op_t;

	localparam reg_idx_t irq_link_reg = 5'd27; // Receives the interrupt return address.
	localparam reg_idx_t irq_target_reg = 5'd26; // Holds the handler address.

	// jalr with rd = 27 and rs = 26, forced into decode by fetch on an interrupt.
	localparam word_t irq_jump_inst = {
		op_rtype, irq_target_reg, 5'd0, irq_link_reg, 5'd0, fn_jalr
	};
	localparam word_t nop_inst = 32'h0000_0000; // Decodes as sll r0, which writes nothing.

endpackage

`default_nettype wire

// ==== files.f ====
common/cpu_pkg.sv
src/cpu_fetch.sv
src/cpu_decode.sv
src/cpu_execute.sv
src/cpu_result.sv
src/cpu_core.sv
sim/cpu_core_asserts.sv
sim/cpu_core_tb.sv

// ==== sim/cpu_core_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_core_asserts (
	input wire logic              clk,
	input wire logic              rst,
	input wire logic              cpu_stall,
	input wire cpu_pkg::word_t    imem_addr,
	input wire logic              wb_en,
	input wire cpu_pkg::reg_idx_t wb_reg
);
	logic [2:0] since_reset; // Edges after reset, saturates at four.

	always_ff @(posedge clk) begin
		if (rst) since_reset <= '0;
		else if (since_reset < 3'd4) since_reset <= since_reset + 3'd1;
	end

	// The first instruction needs four edges to reach writeback.
	wb_off_after_reset: assert property (@(posedge clk) (!rst && since_reset < 3'd4) |-> !wb_en)
		else $error("wb_en high within four cycles of reset");
	wb_reg_nonzero: assert property (@(posedge clk) disable iff (rst) wb_en |-> wb_reg != '0)
		else $error("writeback to register zero");
	imem_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
		else $error("imem_addr not word aligned");
	imem_frozen: assert property (@(posedge clk) disable iff (rst) cpu_stall |=> $stable(imem_addr))
		else $error("imem_addr moved during cpu_stall");

endmodule

bind cpu_core cpu_core_asserts i_cpu_core_asserts (
	.clk       (clk),
	.rst       (rst),
	.cpu_stall (cpu_stall),
	.imem_addr (imem_addr),
	.wb_en     (wb_en),
	.wb_reg    (wb_reg)
);

`default_nettype wire

// ==== sim/cpu_core_golden.txt ====
// Word 000 holds the test count. Rows of the test table start at 008, columns are
// program base, word count, freeze cycle, freeze length, irq cycle, expected base, expected count.
@000
00000005
@008
00000040 0000000c 00000000 00000000 00000000 000000c0 0000000b 00000000
00000050 0000000a 00000000 00000000 00000000 000000e0 00000007 00000000
00000060 00000012 00000000 00000000 00000000 00000100 00000007 00000000
00000080 0000000a 00000006 00000007 00000000 00000120 00000006 00000000
00000090 0000000b 00000000 00000000 0000000e 00000140 00000005 00000000
// Test 1 ALU and immediates with back to back dependencies.
@040
20010005 20220003 00221820 00612022 00832824 00a13025
0022382a 3c081234 35085678 2009ffff 0121502a 0800000b
// Test 2 store then load, and two load use pairs.
@050
20010040 3c02dead 3442beef ac220004 8c230004 20640001 ac240008 8c250008
00a53020 08000009
// Test 3 beq, bne, j, jal, jalr and jr.
@060
20010001 20020002 10220001 20030003 14220001 20040044 10210001 20040055
14210001 0c00000c 20040066 08000010 2005003c 00a03009 20040077 03e00008
20070007 08000011
// Test 4 freeze in the middle of a load and a branch.
@080
20010010 20220020 ac220000 8c230000 00622020 00812822 14a40001 20060001
00a23025 08000009
// Test 5 interrupt during a loop, the handler sits at 0x20.
@090
201a0020 20010011 08000002 00000000 00000000 00000000 00000000 00000000
20020022 00411825 0800000a
// Expected writebacks as register and value. Register bit 8 set accepts any word
// address inside the program.
@0c0
00000001 00000005 00000002 00000008 00000003 0000000d 00000004 00000008
00000005 00000008 00000006 0000000d 00000007 00000001 00000008 12340000
00000008 12345678 00000009 ffffffff 0000000a 00000001
@0e0
00000001 00000040 00000002 dead0000 00000002 deadbeef 00000003 deadbeef
00000004 deadbef0 00000005 deadbef0 00000006 bd5b7de0
@100
00000001 00000001 00000002 00000002 00000003 00000003 0000001f 0000002c
00000005 0000003c 00000006 0000003c 00000007 00000007
@120
00000001 00000010 00000002 00000030 00000003 00000030 00000004 00000060
00000005 00000050 00000006 00000070
@140
0000001a 00000020 00000001 00000011 0000011b 00000000 00000002 00000022
00000003 00000033

// ==== sim/cpu_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_core_tb;
	import cpu_pkg::*;

	localparam int reset_cycles = 16;
	localparam int quiet_cycles = 8; // Cycles watched for stray writebacks after a test.
	localparam int row_base = 8; // First row of the test table in the golden image.
	localparam int row_words = 8;

	logic clk;
	logic rst;
	logic cpu_stall;
	logic irq;
	word_t imem_addr;
	word_t imem_data;
	logic wb_en;
	reg_idx_t wb_reg;
	word_t wb_data;

	word_t golden [512]; // Test table, programs and expected writebacks.
	int cycle_count;
	int cycle_limit;
	int test_num;
	int prog_base;
	int prog_count;
	int exp_base;
	int exp_count;
	int wb_seen;
	int test_errors;
	int total_errors;
	int failed_tests;

	cpu_core #(
		.DMEM_WORDS (256)
	) i_cpu_core (
		.clk       (clk),
		.rst       (rst),
		.cpu_stall (cpu_stall),
		.irq       (irq),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb_en     (wb_en),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data)
	);

	function automatic word_t golden_at(input int idx);
		return golden[idx[8:0]];
	endfunction

	function automatic int row_field(input int t, input int col);
		return int'(golden_at(row_base + t * row_words + col));
	endfunction

	// Instruction memory answers in the same cycle. Outside the program it returns nops.
	always_comb begin
		imem_data = nop_inst;
		if ({2'b00, imem_addr[31:2]} < word_t'(prog_count)) begin
			imem_data = golden_at(prog_base + int'({2'b00, imem_addr[31:2]}));
		end
	end

	always begin
		#20 clk = ~clk; // 40 ns period.
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout in test %0d after %0d cycles, %0d of %0d writebacks seen",
				test_num, cycle_count, wb_seen, exp_count);
			$display("Finished with errors");
			$finish;
		end
	end

	// A value on the writeback port is new only if the last edge was not frozen.
	task automatic check_writeback();
		int idx;
		word_t exp_reg;
		word_t exp_val;
		if (wb_en && !cpu_stall) begin
			if (wb_seen >= exp_count) begin
				$display("Error at %0d ns: unexpected writeback to register %0d in test %0d",
					$time, wb_reg, test_num);
				test_errors++;
			end else begin
				idx = exp_base + 2 * wb_seen; // Pairs of register and value.
				exp_reg = golden_at(idx);
				exp_val = golden_at(idx + 1);
				if (wb_reg != exp_reg[4:0]) begin
					$display("MISMATCH at %0d ns: wb_reg expected %0d got %0d",
						$time, exp_reg[4:0], wb_reg);
					test_errors++;
				end
				if (exp_reg[8]) begin // Only a word address inside the program is known.
					if (wb_data[1:0] != 2'b00 || wb_data >= word_t'(4 * prog_count)) begin
						$display("MISMATCH at %0d ns: wb_data expected word address below %h got %h",
							$time, word_t'(4 * prog_count), wb_data);
						test_errors++;
					end
				end else if (wb_data != exp_val) begin
					$display("MISMATCH at %0d ns: wb_data expected %h got %h",
						$time, exp_val, wb_data);
					test_errors++;
				end
				wb_seen++;
			end
		end
	endtask

	task automatic run_test(input int t);
		int freeze_at;
		int freeze_len;
		int irq_at;
		int c;
		int quiet;
		@(negedge clk);
		rst = 1'b1; // Reset first so the old program never sees the new image.
		cpu_stall = 1'b0;
		irq = 1'b0;
		test_num = t + 1;
		prog_base = row_field(t, 0);
		prog_count = row_field(t, 1);
		freeze_at = row_field(t, 2);
		freeze_len = row_field(t, 3);
		irq_at = row_field(t, 4);
		exp_base = row_field(t, 5);
		exp_count = row_field(t, 6);
		wb_seen = 0;
		test_errors = 0;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
		c = 0;
		quiet = 0;
		while (wb_seen < exp_count || quiet < quiet_cycles) begin
			@(negedge clk);
			check_writeback(); // Sample before the inputs for the next edge change.
			cpu_stall = freeze_len > 0 && c >= freeze_at && c < freeze_at + freeze_len;
			irq = irq_at > 0 && c == irq_at; // One cycle pulse.
			if (wb_seen >= exp_count) quiet++;
			c++;
		end
		cpu_stall = 1'b0;
		irq = 1'b0;
		if (test_errors == 0) begin
			$display("Test %0d passed with %0d writebacks", test_num, wb_seen);
		end else begin
			$display("Test %0d failed with %0d errors", test_num, test_errors);
			failed_tests++;
		end
		total_errors += test_errors;
	endtask

	initial begin
		int n_tests;
		clk = 1'b0;
		rst = 1'b1;
		cpu_stall = 1'b0;
		irq = 1'b0;
		prog_base = 0;
		prog_count = 0;
		exp_base = 0;
		exp_count = 0;
		wb_seen = 0;
		test_num = 0;
		cycle_count = 0;
		total_errors = 0;
		failed_tests = 0;
		$readmemh("sim/cpu_core_golden.txt", golden);
		n_tests = int'(golden_at(0));
		cycle_limit = 50;
		for (int t = 0; t < n_tests; t++) begin
			cycle_limit += reset_cycles + quiet_cycles + 2 * row_field(t, 1) + row_field(t, 3);
		end
		for (int t = 0; t < n_tests; t++) begin
			run_test(t);
		end
		$display("Tests %0d, failed %0d, errors %0d", n_tests, failed_tests, total_errors);
		if (total_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/cpu_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_core #(
	parameter int DMEM_WORDS = 256
) (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire logic           cpu_stall, // Freezes every register and memory write.
	input  wire logic           irq,
	output cpu_pkg::word_t      imem_addr,
	input  wire cpu_pkg::word_t imem_data, // Answered in the same cycle.
	output logic                wb_en,
	output cpu_pkg::reg_idx_t   wb_reg,
	output cpu_pkg::word_t      wb_data
);
	import cpu_pkg::*;

	word_t if_pc;
	word_t if_inst;
	logic branch_taken;
	word_t branch_target;
	logic jump_taken;
	word_t jump_target;
	logic hazard_stall;
	word_t id_pc;
	alu_op_t id_alu_op;
	word_t id_op_a;
	word_t id_op_b;
	reg_idx_t id_rs;
	reg_idx_t id_rt;
	logic id_use_imm;
	word_t id_imm;
	logic id_mem_read;
	logic id_mem_write;
	reg_idx_t id_dest;
	logic id_reg_write;
	logic id_link;
	word_t ex_result;
	word_t ex_store_data;
	reg_idx_t ex_dest;
	logic ex_reg_write;
	logic ex_mem_read;
	logic ex_mem_write;

	cpu_fetch i_cpu_fetch (
		.clk           (clk),
		.rst           (rst),
		.cpu_stall     (cpu_stall),
		.irq           (irq),
		.hazard_stall  (hazard_stall),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.jump_taken    (jump_taken),
		.jump_target   (jump_target),
		.imem_addr     (imem_addr),
		.imem_data     (imem_data),
		.if_pc         (if_pc),
		.if_inst       (if_inst)
	);

	cpu_decode i_cpu_decode (
		.clk           (clk),
		.rst           (rst),
		.cpu_stall     (cpu_stall),
		.if_pc         (if_pc),
		.if_inst       (if_inst),
		.wb_en         (wb_en),
		.wb_reg        (wb_reg),
		.wb_data       (wb_data),
		.ex_dest       (ex_dest),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_read   (ex_mem_read),
		.ex_result     (ex_result),
		.id_pc         (id_pc),
		.id_alu_op     (id_alu_op),
		.id_op_a       (id_op_a),
		.id_op_b       (id_op_b),
		.id_rs         (id_rs),
		.id_rt         (id_rt),
		.id_use_imm    (id_use_imm),
		.id_imm        (id_imm),
		.id_mem_read   (id_mem_read),
		.id_mem_write  (id_mem_write),
		.id_dest       (id_dest),
		.id_reg_write  (id_reg_write),
		.id_link       (id_link),
		.branch_taken  (branch_taken),
		.branch_target (branch_target),
		.jump_taken    (jump_taken),
		.jump_target   (jump_target),
		.hazard_stall  (hazard_stall)
	);

	cpu_execute i_cpu_execute (
		.clk           (clk),
		.rst           (rst),
		.cpu_stall     (cpu_stall),
		.id_pc         (id_pc),
		.id_alu_op     (id_alu_op),
		.id_op_a       (id_op_a),
		.id_op_b       (id_op_b),
		.id_rs         (id_rs),
		.id_rt         (id_rt),
		.id_use_imm    (id_use_imm),
		.id_imm        (id_imm),
		.id_mem_read   (id_mem_read),
		.id_mem_write  (id_mem_write),
		.id_dest       (id_dest),
		.id_reg_write  (id_reg_write),
		.id_link       (id_link),
		.wb_en         (wb_en),
		.wb_reg        (wb_reg),
		.wb_data       (wb_data),
		.ex_result     (ex_result),
		.ex_store_data (ex_store_data),
		.ex_dest       (ex_dest),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (ex_mem_write)
	);

	cpu_result #(
		.DMEM_WORDS (DMEM_WORDS)
	) i_cpu_result (
		.clk           (clk),
		.rst           (rst),
		.cpu_stall     (cpu_stall),
		.ex_result     (ex_result),
		.ex_store_data (ex_store_data),
		.ex_dest       (ex_dest),
		.ex_reg_write  (ex_reg_write),
		.ex_mem_read   (ex_mem_read),
		.ex_mem_write  (ex_mem_write),
		.wb_en         (wb_en),
		.wb_reg        (wb_reg),
		.wb_data       (wb_data)
	);

endmodule

`default_nettype wire

// ==== src/cpu_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_decode (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              cpu_stall,
	input  wire cpu_pkg::word_t    if_pc,
	input  wire cpu_pkg::word_t    if_inst,
	input  wire logic              wb_en,
	input  wire cpu_pkg::reg_idx_t wb_reg,
	input  wire cpu_pkg::word_t    wb_data,
	input  wire cpu_pkg::reg_idx_t ex_dest,
	input  wire logic              ex_reg_write,
	input  wire logic              ex_mem_read,
	input  wire cpu_pkg::word_t    ex_result,
	output cpu_pkg::word_t         id_pc,
	output cpu_pkg::alu_op_t       id_alu_op,
	output cpu_pkg::word_t         id_op_a,
	output cpu_pkg::word_t         id_op_b,
	output cpu_pkg::reg_idx_t      id_rs,
	output cpu_pkg::reg_idx_t      id_rt,
	output logic                   id_use_imm,
	output cpu_pkg::word_t         id_imm,
	output logic                   id_mem_read,
	output logic                   id_mem_write,
	output cpu_pkg::reg_idx_t      id_dest,
	output logic                   id_reg_write,
	output logic                   id_link,
	output logic                   branch_taken,
	output cpu_pkg::word_t         branch_target,
	output logic                   jump_taken,
	output cpu_pkg::word_t         jump_target,
	output logic                   hazard_stall
);
	import cpu_pkg::*;

	word_t regs [32];
	logic [5:0] opcode;
	logic [5:0] funct;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	logic [15:0] imm16;
	word_t pc_plus4;
	word_t rf_rs;
	word_t rf_rt;
	word_t cmp_rs;
	word_t cmp_rt;
	alu_op_t alu_op;
	word_t imm;
	reg_idx_t dest;
	logic use_imm;
	logic mem_read;
	logic mem_write;
	logic reg_write;
	logic link;
	logic is_branch;
	logic jump_imm;
	logic jump_reg;
	logic uses_rs;
	logic uses_rt;
	logic load_use;
	logic branch_hazard;

	assign opcode = if_inst[31:26];
	assign rs = if_inst[25:21];
	assign rt = if_inst[20:16];
	assign rd = if_inst[15:11];
	assign imm16 = if_inst[15:0];
	assign funct = if_inst[5:0];
	assign pc_plus4 = if_pc + 32'd4;

	// Register zero reads as zero; a write retiring this cycle is seen at once.
	function automatic word_t read_reg(input reg_idx_t idx);
		word_t value;
		if (idx == '0) value = '0;
		else if (wb_en && wb_reg == idx) value = wb_data;
		else value = regs[idx];
		return value;
	endfunction

	always_comb begin
		rf_rs = read_reg(rs);
		rf_rt = read_reg(rt);
		// A load in result has no data yet; the hazard check stalls that case.
		cmp_rs = (ex_reg_write && !ex_mem_read && ex_dest == rs) ? ex_result : rf_rs;
		cmp_rt = (ex_reg_write && !ex_mem_read && ex_dest == rt) ? ex_result : rf_rt;
	end

	always_comb begin
		alu_op = alu_add;
		imm = {{16{imm16[15]}}, imm16}; // Sign extended unless the opcode says otherwise.
		dest = rt;
		use_imm = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		reg_write = 1'b0;
		link = 1'b0;
		is_branch = 1'b0;
		jump_imm = 1'b0;
		jump_reg = 1'b0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		case (opcode)
			op_rtype: begin
				dest = rd;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
				reg_write = 1'b1;
				case (funct)
					fn_add: alu_op = alu_add;
					fn_sub: alu_op = alu_sub;
					fn_and: alu_op = alu_and;
					fn_or: alu_op = alu_or;
					fn_slt: alu_op = alu_slt;
					fn_jr: begin
						jump_reg = 1'b1;
						reg_write = 1'b0;
						uses_rt = 1'b0;
					end
					fn_jalr: begin
						jump_reg = 1'b1;
						link = 1'b1;
						uses_rt = 1'b0;
					end
					default: begin // Unsupported functions, nop among them, do nothing.
						reg_write = 1'b0;
						uses_rs = 1'b0;
						uses_rt = 1'b0;
					end
				endcase
			end
			op_addi, op_lw: begin
				use_imm = 1'b1;
				uses_rs = 1'b1;
				reg_write = 1'b1;
				mem_read = opcode == op_lw;
			end
			op_ori, op_lui: begin
				alu_op = (opcode == op_ori) ? alu_or : alu_lui;
				imm = {16'h0000, imm16}; // Logical immediates are zero extended.
				use_imm = 1'b1;
				uses_rs = opcode == op_ori;
				reg_write = 1'b1;
			end
			op_sw: begin
				use_imm = 1'b1;
				mem_write = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1; // Store data.
			end
			op_beq, op_bne: begin
				is_branch = 1'b1;
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			op_j: jump_imm = 1'b1;
			op_jal: begin
				jump_imm = 1'b1;
				link = 1'b1;
				reg_write = 1'b1;
				dest = 5'd31;
			end
			default: ;
		endcase
	end

	// A load in execute cannot forward to the next instruction.
	assign load_use = id_mem_read && id_reg_write &&
		((uses_rs && id_dest == rs) || (uses_rt && id_dest == rt));
	// Compares happen here, so a producer in execute or a load in result must drain.
	assign branch_hazard = (is_branch || jump_reg) &&
		((id_reg_write && (id_dest == rs || (is_branch && id_dest == rt))) ||
		(ex_reg_write && ex_mem_read && (ex_dest == rs || (is_branch && ex_dest == rt))));
	assign hazard_stall = load_use || branch_hazard;

	assign branch_taken = is_branch && !hazard_stall &&
		((cmp_rs == cmp_rt) == (opcode == op_beq));
	assign branch_target = pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
	assign jump_taken = (jump_imm || jump_reg) && !hazard_stall;
	assign jump_target = jump_reg ? cmp_rs : {pc_plus4[31:28], if_inst[25:0], 2'b00};

	always_ff @(posedge clk) begin
		if (!cpu_stall && wb_en) begin
			regs[wb_reg] <= wb_data; // wb_reg is never zero while wb_en is high.
		end
	end

	always_ff @(posedge clk) begin
		if (!cpu_stall) begin
			id_pc <= if_pc;
			id_alu_op <= alu_op;
			id_op_a <= rf_rs;
			id_op_b <= rf_rt;
			id_rs <= rs;
			id_rt <= rt;
			id_use_imm <= use_imm;
			id_imm <= imm;
			id_dest <= dest;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			id_mem_read <= 1'b0;
			id_mem_write <= 1'b0;
			id_reg_write <= 1'b0;
			id_link <= 1'b0;
		end else if (!cpu_stall) begin
			id_mem_read <= mem_read && !hazard_stall; // A stall sends a bubble to execute.
			id_mem_write <= mem_write && !hazard_stall;
			id_reg_write <= reg_write && dest != '0 && !hazard_stall;
			id_link <= link && !hazard_stall;
		end
	end

endmodule

`default_nettype wire

// ==== src/cpu_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_execute (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              cpu_stall,
	input  wire cpu_pkg::word_t    id_pc,
	input  wire cpu_pkg::alu_op_t  id_alu_op,
	input  wire cpu_pkg::word_t    id_op_a,
	input  wire cpu_pkg::word_t    id_op_b,
	input  wire cpu_pkg::reg_idx_t id_rs,
	input  wire cpu_pkg::reg_idx_t id_rt,
	input  wire logic              id_use_imm,
	input  wire cpu_pkg::word_t    id_imm,
	input  wire logic              id_mem_read,
	input  wire logic              id_mem_write,
	input  wire cpu_pkg::reg_idx_t id_dest,
	input  wire logic              id_reg_write,
	input  wire logic              id_link,
	input  wire logic              wb_en,
	input  wire cpu_pkg::reg_idx_t wb_reg,
	input  wire cpu_pkg::word_t    wb_data,
	output cpu_pkg::word_t         ex_result,
	output cpu_pkg::word_t         ex_store_data,
	output cpu_pkg::reg_idx_t      ex_dest,
	output logic                   ex_reg_write,
	output logic                   ex_mem_read,
	output logic                   ex_mem_write
);
	import cpu_pkg::*;

	word_t fwd_a;
	word_t fwd_b;
	word_t alu_b;
	word_t alu_out;

	// The instruction one ahead wins over the one two ahead.
	function automatic word_t forward(input reg_idx_t idx, input word_t reg_value);
		word_t value;
		if (ex_reg_write && !ex_mem_read && ex_dest == idx) value = ex_result;
		else if (wb_en && wb_reg == idx) value = wb_data;
		else value = reg_value;
		return value;
	endfunction

	always_comb begin
		fwd_a = forward(id_rs, id_op_a);
		fwd_b = forward(id_rt, id_op_b);
		alu_b = id_use_imm ? id_imm : fwd_b;
		case (id_alu_op)
			alu_add: alu_out = fwd_a + alu_b;
			alu_sub: alu_out = fwd_a - alu_b;
			alu_and: alu_out = fwd_a & alu_b;
			alu_or: alu_out = fwd_a | alu_b;
			alu_slt: alu_out = {31'd0, $signed(fwd_a) < $signed(alu_b)};
			alu_lui: alu_out = {alu_b[15:0], 16'h0000};
			default: alu_out = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!cpu_stall) begin
			ex_result <= id_link ? id_pc + 32'd8 : alu_out; // jal and jalr save pc + 8.
			ex_store_data <= fwd_b; // Store data is rt after forwarding.
			ex_dest <= id_dest;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
		end else if (!cpu_stall) begin
			ex_reg_write <= id_reg_write;
			ex_mem_read <= id_mem_read;
			ex_mem_write <= id_mem_write;
		end
	end

endmodule

`default_nettype wire

// ==== src/cpu_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_fetch (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire logic           cpu_stall,
	input  wire logic           irq,
	input  wire logic           hazard_stall,
	input  wire logic           branch_taken,
	input  wire cpu_pkg::word_t branch_target,
	input  wire logic           jump_taken,
	input  wire cpu_pkg::word_t jump_target,
	output cpu_pkg::word_t      imem_addr,
	input  wire cpu_pkg::word_t imem_data,
	output cpu_pkg::word_t      if_pc,
	output cpu_pkg::word_t      if_inst
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		irq_idle, // Normal fetch, irq is sampled here only.
		irq_wait, // Lets a control transfer or stall settle first.
		irq_jump, // Replaces the word at pc with the injected jalr.
		irq_nop // jalr sits in decode, its redirect loads the nop.
	} irq_state_t;

	irq_state_t irq_state;
	irq_state_t irq_next;
	word_t pc;
	word_t next_pc;
	logic redirect;
	logic fetch_ctrl;
	logic [5:0] fetch_op;
	logic [5:0] fetch_fn;

	assign fetch_op = imem_data[31:26];
	assign fetch_fn = imem_data[5:0];
	// The word being fetched now could redirect in decode next cycle.
	assign fetch_ctrl = fetch_op == op_beq || fetch_op == op_bne ||
		fetch_op == op_j || fetch_op == op_jal ||
		(fetch_op == op_rtype && (fetch_fn == fn_jr || fetch_fn == fn_jalr));

	assign redirect = branch_taken || jump_taken; // Decode already masks these during a stall.
	assign next_pc = branch_taken ? branch_target : // Branch wins over jump.
		jump_taken ? jump_target :
		pc + 32'd4;
	assign imem_addr = pc;

	always_comb begin
		irq_next = irq_state;
		case (irq_state)
			irq_idle: begin
				if (irq) begin
					irq_next = (fetch_ctrl || redirect || hazard_stall) ? irq_wait : irq_jump;
				end
			end
			irq_wait: if (!hazard_stall) irq_next = irq_jump;
			irq_jump: if (!hazard_stall) irq_next = irq_nop;
			irq_nop: if (redirect) irq_next = irq_idle; // Handler address is on its way.
			default: irq_next = irq_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			if_inst <= nop_inst;
			irq_state <= irq_idle;
		end else if (!cpu_stall) begin
			irq_state <= irq_next;
			if (redirect) begin
				pc <= next_pc;
				if_inst <= nop_inst; // Flush the word behind the branch, no delay slot.
			end else if (!hazard_stall) begin
				case (irq_state)
					irq_wait: if_inst <= nop_inst; // pc holds, that word is fetched later.
					irq_jump: if_inst <= irq_jump_inst; // pc holds as the return address.
					default: begin
						pc <= next_pc;
						if_inst <= imem_data;
					end
				endcase
			end
		end
	end

	// The link adds eight, so the injected jalr saves the pc it displaced.
	always_ff @(posedge clk) begin
		if (!cpu_stall && !redirect && !hazard_stall) begin
			if_pc <= (irq_state == irq_jump) ? pc - 32'd8 : pc;
		end
	end

endmodule

`default_nettype wire

// ==== src/cpu_result.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_result #(
	parameter int DMEM_WORDS = 256 // Power of two.
) (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire logic              cpu_stall,
	input  wire cpu_pkg::word_t    ex_result,
	input  wire cpu_pkg::word_t    ex_store_data,
	input  wire cpu_pkg::reg_idx_t ex_dest,
	input  wire logic              ex_reg_write,
	input  wire logic              ex_mem_read,
	input  wire logic              ex_mem_write,
	output logic                   wb_en,
	output cpu_pkg::reg_idx_t      wb_reg,
	output cpu_pkg::word_t         wb_data
);
	import cpu_pkg::*;

	localparam int addr_bits = $clog2(DMEM_WORDS);

	word_t dmem [DMEM_WORDS];
	logic [addr_bits-1:0] dmem_idx;
	word_t load_data;

	// Word addressed; upper address bits wrap around the memory.
	assign dmem_idx = ex_result[addr_bits+1:2];
	assign load_data = dmem[dmem_idx];

	always_ff @(posedge clk) begin
		if (!cpu_stall && ex_mem_write) begin
			dmem[dmem_idx] <= ex_store_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!cpu_stall) begin
			wb_reg <= ex_dest;
			wb_data <= ex_mem_read ? load_data : ex_result;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_en <= 1'b0;
		end else if (!cpu_stall) begin
			wb_en <= ex_reg_write && ex_dest != '0; // Register zero never retires a write.
		end
	end

endmodule

`default_nettype wire
